/* common/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	// ########################################
	// Data types
	// ########################################

	typedef logic signed [7:0] data_t;     // Matrix element
	typedef logic signed [23:0] acc_t;     // Accumulator and result

	localparam int IDX_WIDTH = 8;
	localparam int ADDR_WIDTH = 12;

	// ########################################
	// Step and result structs
	// ########################################

	typedef struct packed {
		logic                 valid;
		logic [IDX_WIDTH-1:0] m;       // Row of A
		logic [IDX_WIDTH-1:0] n;       // Column of B
		logic [IDX_WIDTH-1:0] kt;      // Inner tile index
		logic                 first;   // kt == 0
		logic                 last;    // Final kt
	} tile_step_t;

	typedef struct packed {
		acc_t                 value;
		logic [IDX_WIDTH-1:0] m;
		logic [IDX_WIDTH-1:0] n;
		logic                 last;    // Final element of C
	} conv_result_t;

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN
	} ctrl_state_e;

endpackage

`default_nettype wire

/* source/conv_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_controller #(
	parameter int ARRAY_WIDTH = 4,
	parameter int MAT_M = 4,
	parameter int MAT_K = 10,
	parameter int MAT_N = 3
) (
	input  wire                    clk,
	input  wire                    reset,
	input  wire                    start,
	input  wire                    result_valid,
	input  wire conv_pkg::conv_result_t result,
	output conv_pkg::tile_step_t   step,
	output logic                   busy,
	output logic                   done
);
	import conv_pkg::*;

	localparam int K_TILES = (MAT_K + ARRAY_WIDTH - 1) / ARRAY_WIDTH;
	localparam logic [IDX_WIDTH-1:0] LAST_KT = IDX_WIDTH'(K_TILES - 1);
	localparam logic [IDX_WIDTH-1:0] LAST_N = IDX_WIDTH'(MAT_N - 1);
	localparam logic [IDX_WIDTH-1:0] LAST_M = IDX_WIDTH'(MAT_M - 1);

	ctrl_state_e state;
	logic kt_wrap;
	logic n_wrap;
	logic m_wrap;
	logic [IDX_WIDTH-1:0] next_kt;

	assign kt_wrap = (step.kt == LAST_KT);
	assign n_wrap = (step.n == LAST_N);
	assign m_wrap = (step.m == LAST_M);
	assign next_kt = kt_wrap ? '0 : step.kt + 1'b1;
	assign busy = (state != IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: if (start) begin
					state <= RUN;
					step.valid <= 1'b1;
					step.m <= '0;
					step.n <= '0;
					step.kt <= '0;
					step.first <= 1'b1;
					step.last <= (LAST_KT == '0);
				end
				RUN: if (kt_wrap && n_wrap && m_wrap) begin
					state <= DRAIN;
					step.valid <= 1'b0;
				end else begin
					step.kt <= next_kt;
					step.first <= kt_wrap;
					step.last <= (next_kt == LAST_KT);
					if (kt_wrap) begin    // Next output element
						step.n <= n_wrap ? '0 : step.n + 1'b1;
						if (n_wrap)
							step.m <= step.m + 1'b1;
					end
				end
				DRAIN: if (result_valid && result.last) begin
					state <= IDLE;
					done <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done);
	a_step_in_run: assert property (@(posedge clk) disable iff (reset)
		step.valid |-> (state == RUN));

endmodule

`default_nettype wire

/* tiling/act_tiler.sv */
`timescale 1ns/1ps
`default_nettype none

module act_tiler #(
	parameter int ARRAY_WIDTH = 4,
	parameter int MAT_M = 4,
	parameter int MAT_K = 10
) (
	input  wire                                clk,
	input  wire                                act_wr,
	input  wire [conv_pkg::ADDR_WIDTH-1:0]     act_wr_addr,
	input  wire conv_pkg::data_t               act_wr_data,
	input  wire                                busy,
	input  wire conv_pkg::tile_step_t          step,
	output conv_pkg::data_t [ARRAY_WIDTH-1:0]  act_vec
);
	import conv_pkg::*;

	localparam int DEPTH = MAT_M * MAT_K;
	localparam int AW = $clog2(DEPTH);

	data_t act_mem [DEPTH];
	logic [ADDR_WIDTH-1:0] row_base;
	logic [ADDR_WIDTH-1:0] k_base;
	logic [ADDR_WIDTH-1:0] lane_k [ARRAY_WIDTH];
	logic [ADDR_WIDTH-1:0] rd_addr [ARRAY_WIDTH];
	logic [ARRAY_WIDTH-1:0] lane_ok;

	assign row_base = ADDR_WIDTH'(step.m) * ADDR_WIDTH'(MAT_K);
	assign k_base = ADDR_WIDTH'(step.kt) * ADDR_WIDTH'(ARRAY_WIDTH);

	always_comb begin
		for (int lane = 0; lane < ARRAY_WIDTH; lane++) begin
			lane_k[lane] = k_base + ADDR_WIDTH'(lane);
			rd_addr[lane] = row_base + lane_k[lane];
			lane_ok[lane] = step.valid && (lane_k[lane] < ADDR_WIDTH'(MAT_K));  // Pad past K
		end
	end

	always_ff @(posedge clk) begin
		if (act_wr && !busy)
			act_mem[act_wr_addr[AW-1:0]] <= act_wr_data;
	end

	always_ff @(posedge clk) begin
		for (int lane = 0; lane < ARRAY_WIDTH; lane++) begin
			if (lane_ok[lane])
				act_vec[lane] <= act_mem[rd_addr[lane][AW-1:0]];
			else
				act_vec[lane] <= '0;
		end
	end

	a_wr_range: assert property (@(posedge clk)
		(act_wr && !busy) |-> (act_wr_addr < DEPTH));

endmodule

`default_nettype wire

/* tiling/weight_tiler.sv */
`timescale 1ns/1ps
`default_nettype none

module weight_tiler #(
	parameter int ARRAY_WIDTH = 4,
	parameter int MAT_K = 10,
	parameter int MAT_N = 3
) (
	input  wire                                clk,
	input  wire                                weight_wr,
	input  wire [conv_pkg::ADDR_WIDTH-1:0]     weight_wr_addr,
	input  wire conv_pkg::data_t               weight_wr_data,
	input  wire                                busy,
	input  wire conv_pkg::tile_step_t          step,
	output conv_pkg::data_t [ARRAY_WIDTH-1:0]  weight_vec
);
	import conv_pkg::*;

	localparam int DEPTH = MAT_K * MAT_N;
	localparam int AW = $clog2(DEPTH);

	data_t weight_mem [DEPTH];
	logic [ADDR_WIDTH-1:0] k_base;
	logic [ADDR_WIDTH-1:0] lane_k [ARRAY_WIDTH];
	logic [ADDR_WIDTH-1:0] rd_addr [ARRAY_WIDTH];
	logic [ARRAY_WIDTH-1:0] lane_ok;

	assign k_base = ADDR_WIDTH'(step.kt) * ADDR_WIDTH'(ARRAY_WIDTH);

	// Column n, rows k_base up to k_base + ARRAY_WIDTH - 1
	always_comb begin
		for (int lane = 0; lane < ARRAY_WIDTH; lane++) begin
			lane_k[lane] = k_base + ADDR_WIDTH'(lane);
			rd_addr[lane] = lane_k[lane] * ADDR_WIDTH'(MAT_N) + ADDR_WIDTH'(step.n);
			lane_ok[lane] = step.valid && (lane_k[lane] < ADDR_WIDTH'(MAT_K));
		end
	end

	always_ff @(posedge clk) begin
		if (weight_wr && !busy)
			weight_mem[weight_wr_addr[AW-1:0]] <= weight_wr_data;
	end

	always_ff @(posedge clk) begin
		for (int lane = 0; lane < ARRAY_WIDTH; lane++) begin
			if (lane_ok[lane])
				weight_vec[lane] <= weight_mem[rd_addr[lane][AW-1:0]];
			else
				weight_vec[lane] <= '0;      // Padded lane
		end
	end

	a_wr_range: assert property (@(posedge clk)
		(weight_wr && !busy) |-> (weight_wr_addr < DEPTH));

endmodule

`default_nettype wire

/* source/dot_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module dot_engine #(
	parameter int ARRAY_WIDTH = 4,
	parameter int MAT_M = 4,
	parameter int MAT_N = 3
) (
	input  wire                                    clk,
	input  wire                                    reset,
	input  wire conv_pkg::tile_step_t              step,
	input  wire conv_pkg::data_t [ARRAY_WIDTH-1:0] act_vec,
	input  wire conv_pkg::data_t [ARRAY_WIDTH-1:0] weight_vec,
	input  wire                                    relu_en,
	input  wire                                    start,
	output conv_pkg::conv_result_t                 result,
	output logic                                   result_valid
);
	import conv_pkg::*;

	localparam logic [IDX_WIDTH-1:0] LAST_M = IDX_WIDTH'(MAT_M - 1);
	localparam logic [IDX_WIDTH-1:0] LAST_N = IDX_WIDTH'(MAT_N - 1);

	tile_step_t step_d;                // Aligned with tiler vectors
	logic relu_q;
	acc_t acc;
	acc_t lane_sum;
	acc_t total;

	always_comb begin
		lane_sum = '0;
		for (int lane = 0; lane < ARRAY_WIDTH; lane++)
			lane_sum = lane_sum + acc_t'(act_vec[lane]) * acc_t'(weight_vec[lane]);
		total = step_d.first ? lane_sum : acc + lane_sum;
	end

	// ########################################
	// Control
	// ########################################

	always_ff @(posedge clk) begin
		if (reset) begin
			step_d <= '0;
			relu_q <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			step_d <= step;
			result_valid <= step_d.valid && step_d.last;
			if (start && !step.valid && !step_d.valid)   // Only between runs
				relu_q <= relu_en;
		end
	end

	// ########################################
	// Accumulator and result
	// ########################################

	always_ff @(posedge clk) begin
		if (step_d.valid)
			acc <= total;
		if (step_d.valid && step_d.last) begin
			result.value <= (relu_q && total < 0) ? '0 : total;
			result.m <= step_d.m;
			result.n <= step_d.n;
			result.last <= (step_d.m == LAST_M) && (step_d.n == LAST_N);
		end
	end

	a_acc_chain: assert property (@(posedge clk) disable iff (reset)
		(step_d.valid && !step_d.first) |-> $past(step_d.valid));

endmodule

`default_nettype wire

/* source/conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_top #(
	parameter int ARRAY_WIDTH = 4,
	parameter int MAT_M = 4,
	parameter int MAT_K = 10,
	parameter int MAT_N = 3
) (
	input  wire                            clk,
	input  wire                            reset,
	input  wire                            act_wr,
	input  wire [conv_pkg::ADDR_WIDTH-1:0] act_wr_addr,
	input  wire conv_pkg::data_t           act_wr_data,
	input  wire                            weight_wr,
	input  wire [conv_pkg::ADDR_WIDTH-1:0] weight_wr_addr,
	input  wire conv_pkg::data_t           weight_wr_data,
	input  wire                            start,
	input  wire                            relu_en,
	output wire                            result_valid,
	output wire conv_pkg::conv_result_t    result,
	output wire                            busy,
	output wire                            done
);
	import conv_pkg::*;

	wire tile_step_t step;
	wire data_t [ARRAY_WIDTH-1:0] act_vec;
	wire data_t [ARRAY_WIDTH-1:0] weight_vec;

	conv_controller #(.ARRAY_WIDTH(ARRAY_WIDTH), .MAT_M(MAT_M), .MAT_K(MAT_K), .MAT_N(MAT_N))
	u_controller (
		.clk(clk), .reset(reset), .start(start),
		.result_valid(result_valid), .result(result),
		.step(step), .busy(busy), .done(done)
	);

	act_tiler #(.ARRAY_WIDTH(ARRAY_WIDTH), .MAT_M(MAT_M), .MAT_K(MAT_K)) u_act_tiler (
		.clk(clk), .act_wr(act_wr), .act_wr_addr(act_wr_addr), .act_wr_data(act_wr_data),
		.busy(busy), .step(step), .act_vec(act_vec)
	);

	weight_tiler #(.ARRAY_WIDTH(ARRAY_WIDTH), .MAT_K(MAT_K), .MAT_N(MAT_N)) u_weight_tiler (
		.clk(clk), .weight_wr(weight_wr), .weight_wr_addr(weight_wr_addr),
		.weight_wr_data(weight_wr_data), .busy(busy), .step(step), .weight_vec(weight_vec)
	);

	dot_engine #(.ARRAY_WIDTH(ARRAY_WIDTH), .MAT_M(MAT_M), .MAT_N(MAT_N)) u_dot_engine (
		.clk(clk), .reset(reset), .step(step),
		.act_vec(act_vec), .weight_vec(weight_vec),
		.relu_en(relu_en), .start(start),
		.result(result), .result_valid(result_valid)
	);

endmodule

`default_nettype wire

/* test/conv_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_tb;
	import conv_pkg::*;

	localparam int ARRAY_WIDTH = 4;
	localparam int MAT_M = 4;
	localparam int MAT_K = 10;
	localparam int MAT_N = 3;
	localparam int K_TILES = (MAT_K + ARRAY_WIDTH - 1) / ARRAY_WIDTH;
	localparam int A_SIZE = MAT_M * MAT_K;
	localparam int B_SIZE = MAT_K * MAT_N;
	localparam int LOAD_CYCLES = A_SIZE + B_SIZE;
	localparam int NUM_TESTS = 6;
	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES
		+ NUM_TESTS * (LOAD_CYCLES + MAT_M * MAT_N * K_TILES + 20);

	logic clk = 1'b0;
	logic reset;
	logic act_wr;
	logic [ADDR_WIDTH-1:0] act_wr_addr;
	data_t act_wr_data;
	logic weight_wr;
	logic [ADDR_WIDTH-1:0] weight_wr_addr;
	data_t weight_wr_data;
	logic start;
	logic relu_en;
	logic result_valid;
	conv_result_t result;
	logic busy;
	logic done;

	data_t a_mat [MAT_M][MAT_K];
	data_t b_mat [MAT_K][MAT_N];
	conv_result_t got_q [$];
	int errors = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int done_count = 0;
	int cycle_count = 0;
	logic prev_last = 1'b0;

	conv_top #(.ARRAY_WIDTH(ARRAY_WIDTH), .MAT_M(MAT_M), .MAT_K(MAT_K), .MAT_N(MAT_N)) u_dut (
		.clk(clk), .reset(reset),
		.act_wr(act_wr), .act_wr_addr(act_wr_addr), .act_wr_data(act_wr_data),
		.weight_wr(weight_wr), .weight_wr_addr(weight_wr_addr),
		.weight_wr_data(weight_wr_data),
		.start(start), .relu_en(relu_en),
		.result_valid(result_valid), .result(result), .busy(busy), .done(done)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// ########################################
	// Checks and model
	// ########################################

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			$display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_result(input conv_result_t got, input conv_result_t exp);
		checks++;
		if (got.value !== exp.value) begin
			$display("FAILED at %0t: result.value got %0d expected %0d",
				$time, got.value, exp.value);
			errors++;
		end
		if (got.m !== exp.m || got.n !== exp.n) begin
			$display("FAILED at %0t: result.m/n got %0d/%0d expected %0d/%0d",
				$time, got.m, got.n, exp.m, exp.n);
			errors++;
		end
		if (got.last !== exp.last) begin
			$display("FAILED at %0t: result.last got %b expected %b", $time, got.last, exp.last);
			errors++;
		end
	endtask

	function automatic conv_result_t model_result(input int m, input int n, input logic relu);
		conv_result_t r;
		int sum;
		int k;
		sum = 0;
		for (k = 0; k < MAT_K; k++)
			sum += int'(a_mat[m][k]) * int'(b_mat[k][n]);
		if (relu && sum < 0)
			sum = 0;
		r.value = acc_t'(sum);
		r.m = IDX_WIDTH'(m);
		r.n = IDX_WIDTH'(n);
		r.last = (m == MAT_M - 1) && (n == MAT_N - 1);
		return r;
	endfunction

	// Result and done monitor on the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (result_valid) begin
				got_q.push_back(result);
				check_flag("busy", busy, 1'b1);
			end
			if (done) begin
				done_count++;
				check_flag("busy", busy, 1'b0);
				if (!prev_last) begin
					$display("Error at %0t: done pulsed without a last result before it", $time);
					errors++;
				end
			end
			prev_last = result_valid && result.last;
		end
	end

	// ########################################
	// Stimulus
	// ########################################

	function automatic data_t pick_extreme();
		return ($urandom % 2 != 0) ? data_t'(127) : data_t'(-128);
	endfunction

	task automatic fill_matrices(input bit extreme);
		int i;
		int j;
		for (i = 0; i < MAT_M; i++)
			for (j = 0; j < MAT_K; j++)
				a_mat[i][j] = !extreme ? data_t'($urandom) : (i == 0) ? data_t'(-128) : pick_extreme();
		for (i = 0; i < MAT_K; i++)
			for (j = 0; j < MAT_N; j++)
				b_mat[i][j] = !extreme ? data_t'($urandom) : (j == 0) ? data_t'(-128) : pick_extreme();
	endtask

	task automatic load_matrices();
		int i;
		int count;
		count = (A_SIZE > B_SIZE) ? A_SIZE : B_SIZE;
		for (i = 0; i < count; i++) begin   // Both buffers in parallel
			@(posedge clk);
			act_wr <= (i < A_SIZE);
			act_wr_addr <= ADDR_WIDTH'(i);
			act_wr_data <= a_mat[(i / MAT_K) % MAT_M][i % MAT_K];
			weight_wr <= (i < B_SIZE);
			weight_wr_addr <= ADDR_WIDTH'(i);
			weight_wr_data <= b_mat[(i / MAT_N) % MAT_K][i % MAT_N];
		end
		@(posedge clk);
		act_wr <= 1'b0;
		weight_wr <= 1'b0;
	endtask

	task automatic run_matrix(input logic relu, input int disturb, input bit extra_start);
		int i;
		int done_before;
		conv_result_t exp_r;
		got_q.delete();
		done_before = done_count;
		@(posedge clk);
		start <= 1'b1;
		relu_en <= relu;
		@(posedge clk);
		start <= 1'b0;
		relu_en <= !relu;                   // Only the start cycle counts
		for (i = 0; i < disturb; i++) begin  // Writes well inside the busy window
			@(posedge clk);
			act_wr <= 1'b1;
			act_wr_addr <= ADDR_WIDTH'($urandom % A_SIZE);
			act_wr_data <= data_t'($urandom);
			weight_wr <= 1'b1;
			weight_wr_addr <= ADDR_WIDTH'($urandom % B_SIZE);
			weight_wr_data <= data_t'($urandom);
		end
		@(posedge clk);
		act_wr <= 1'b0;
		weight_wr <= 1'b0;
		if (extra_start) begin
			repeat (8) @(posedge clk);
			start <= 1'b1;
			@(posedge clk);
			start <= 1'b0;
		end
		while (done_count == done_before)
			@(negedge clk);
		repeat (8) @(negedge clk);          // Room for stray results
		if (got_q.size() != MAT_M * MAT_N) begin
			$display("Error at %0t: expected %0d results but got %0d",
				$time, MAT_M * MAT_N, got_q.size());
			errors++;
		end
		for (i = 0; i < got_q.size() && i < MAT_M * MAT_N; i++) begin
			exp_r = model_result(i / MAT_N, i % MAT_N, relu);
			check_result(got_q[i], exp_r);
		end
		if (done_count - done_before != 1) begin
			$display("Error at %0t: done pulsed %0d times instead of once",
				$time, done_count - done_before);
			errors++;
		end
		check_flag("busy", busy, 1'b0);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %-20s PASS", name);
		end else begin
			$display("test %-20s FAIL (%0d errors)", name, errors - errs_before);
			tests_failed++;
		end
	endtask

	initial begin
		int errs_before;
		void'($urandom(32'h56ab_0f7c));
		reset = 1'b1;
		start = 1'b0;
		relu_en = 1'b0;
		act_wr = 1'b0;
		act_wr_addr = '0;
		act_wr_data = '0;
		weight_wr = 1'b0;
		weight_wr_addr = '0;
		weight_wr_data = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		errs_before = errors;
		@(negedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_flag("result_valid", result_valid, 1'b0);
		finish_test("reset_state", errs_before);

		errs_before = errors;
		fill_matrices(1'b0);
		load_matrices();
		run_matrix(1'b0, 0, 1'b0);
		finish_test("random_no_relu", errs_before);

		errs_before = errors;
		run_matrix(1'b1, 0, 1'b0);
		finish_test("random_relu", errs_before);

		errs_before = errors;
		fill_matrices(1'b1);
		load_matrices();
		run_matrix(1'b0, 0, 1'b0);
		finish_test("extreme_operands", errs_before);

		errs_before = errors;
		fill_matrices(1'b0);
		load_matrices();
		run_matrix(1'b0, 20, 1'b0);
		run_matrix(1'b0, 0, 1'b0);           // Buffers must be unchanged
		finish_test("writes_while_busy", errs_before);

		errs_before = errors;
		fill_matrices(1'b0);
		load_matrices();
		run_matrix(1'b1, 0, 1'b1);
		finish_test("start_while_busy", errs_before);

		$display("Tests: %0d run, %0d failed; checks: %0d; errors: %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
common/conv_pkg.sv
source/conv_controller.sv
tiling/act_tiler.sv
tiling/weight_tiler.sv
source/dot_engine.sv
source/conv_top.sv
test/conv_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= conv_tb
FILELIST ?= filelist.f
BUILD_DIR ?= build
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal
FAIL_MSG ?= Simulation failed
PASS_MSG ?= Simulation passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
